// File: rtl/alu_isa_pkg.sv
package alu_isa_pkg;

	// one-hot operation class, driven by the decode stage
	localparam logic [15:0] ENCODING_LUI       = 16'h0001;
	localparam logic [15:0] ENCODING_AUIPC     = 16'h0002;
	localparam logic [15:0] ENCODING_ARITH_IMM = 16'h0010;
	localparam logic [15:0] ENCODING_ARITH_REG = 16'h0020;

	// rv32i func3
	localparam logic [2:0] FUNC3_ADD  = 3'b000;  // add / sub
	localparam logic [2:0] FUNC3_SLL  = 3'b001;
	localparam logic [2:0] FUNC3_SLT  = 3'b010;
	localparam logic [2:0] FUNC3_SLTU = 3'b011;
	localparam logic [2:0] FUNC3_XOR  = 3'b100;
	localparam logic [2:0] FUNC3_SR   = 3'b101;  // srl / sra
	localparam logic [2:0] FUNC3_OR   = 3'b110;
	localparam logic [2:0] FUNC3_AND  = 3'b111;

	// rv32m func3
	localparam logic [2:0] FUNC3_MUL    = 3'b000;
	localparam logic [2:0] FUNC3_MULH   = 3'b001;
	localparam logic [2:0] FUNC3_MULHSU = 3'b010;
	localparam logic [2:0] FUNC3_MULHU  = 3'b011;
	localparam logic [2:0] FUNC3_DIV    = 3'b100;
	localparam logic [2:0] FUNC3_DIVU   = 3'b101;
	localparam logic [2:0] FUNC3_REM    = 3'b110;
	localparam logic [2:0] FUNC3_REMU   = 3'b111;

	// func7 field values
	localparam logic [6:0] RV32M_FUNC7 = 7'b0000001;  // marks mul/div ops
	localparam logic [6:0] FUNC7_ALT   = 7'b0100000;  // sub, sra

endpackage

// File: rtl/alu_cfg_pkg.sv
package alu_cfg_pkg;

	// datapath width
	localparam int XLEN    = 32;
	localparam int SHAMT_W = $clog2(XLEN);  // shift amount bits

	// register stages behind the multiplier array
	localparam int MUL_STAGES = 2;

	// one quotient bit per iteration
	localparam int DIV_ITER  = 32;
	localparam int DIV_CNT_W = $clog2(DIV_ITER);

endpackage

// File: rtl/riscv_32i_alu.sv
`timescale 1ns/10ps

module riscv_32i_alu (
	input  logic [alu_cfg_pkg::XLEN-1:0] in0_i,       // rs1
	input  logic [alu_cfg_pkg::XLEN-1:0] in1_i,       // rs2
	input  logic [alu_cfg_pkg::XLEN-1:0] imm0_i,      // immediate, already extended
	input  logic [alu_cfg_pkg::XLEN-1:0] addr_i,      // pc for auipc
	input  logic [15:0]                  encoding_i,
	input  logic [2:0]                   func3_i,
	input  logic [6:0]                   func7_i,
	output logic [alu_cfg_pkg::XLEN-1:0] out_o
);

	logic                            is_reg;
	logic                            alt;
	logic [alu_cfg_pkg::XLEN-1:0]    op_b;
	logic [alu_cfg_pkg::SHAMT_W-1:0] shamt;
	logic                            lt_s;
	logic                            lt_u;

	assign is_reg = (encoding_i == alu_isa_pkg::ENCODING_ARITH_REG);
	assign alt    = (func7_i == alu_isa_pkg::FUNC7_ALT);
	assign op_b   = is_reg ? in1_i : imm0_i;  // second operand
	assign shamt  = op_b[alu_cfg_pkg::SHAMT_W-1:0];
	assign lt_s   = $signed(in0_i) < $signed(op_b);
	assign lt_u   = in0_i < op_b;

	always_comb begin
		out_o = '0;
		case (encoding_i)
			alu_isa_pkg::ENCODING_LUI: begin
				out_o = imm0_i;  // upper immediate arrives pre-shifted
			end
			alu_isa_pkg::ENCODING_AUIPC: begin
				out_o = addr_i + imm0_i;
			end
			alu_isa_pkg::ENCODING_ARITH_REG,
			alu_isa_pkg::ENCODING_ARITH_IMM: begin
				case (func3_i)
					alu_isa_pkg::FUNC3_ADD: begin
						// addi has no subtract form
						if (is_reg && alt) begin
							out_o = in0_i - op_b;
						end else begin
							out_o = in0_i + op_b;
						end
					end
					alu_isa_pkg::FUNC3_SLL: out_o = in0_i << shamt;
					alu_isa_pkg::FUNC3_SLT: out_o = {{(alu_cfg_pkg::XLEN-1){1'b0}}, lt_s};
					alu_isa_pkg::FUNC3_SLTU: out_o = {{(alu_cfg_pkg::XLEN-1){1'b0}}, lt_u};
					alu_isa_pkg::FUNC3_XOR: out_o = in0_i ^ op_b;
					alu_isa_pkg::FUNC3_SR: begin
						if (alt) begin
							out_o = $signed(in0_i) >>> shamt;  // sra / srai
						end else begin
							out_o = in0_i >> shamt;
						end
					end
					alu_isa_pkg::FUNC3_OR: out_o = in0_i | op_b;
					alu_isa_pkg::FUNC3_AND: out_o = in0_i & op_b;
					default: out_o = '0;
				endcase
			end
			default: out_o = '0;  // not an alu class
		endcase
	end

endmodule

// File: rtl/riscv_32m_div.sv
`timescale 1ns/10ps

module riscv_32m_div (
	input  logic                         clock_div_i,
	input  logic                         rst_n_i,
	input  logic                         start_i,      // one cycle pulse
	input  logic [alu_cfg_pkg::XLEN-1:0] dividend_i,
	input  logic [alu_cfg_pkg::XLEN-1:0] divisor_i,
	output logic                         done_o,
	output logic [alu_cfg_pkg::XLEN-1:0] quotient_o,
	output logic [alu_cfg_pkg::XLEN-1:0] remainder_o
);

	logic                              busy_q;
	logic                              done_q;
	logic [alu_cfg_pkg::DIV_CNT_W-1:0] cnt_q;
	logic [alu_cfg_pkg::XLEN-1:0]      quo_q;   // dividend shifts out, quotient in
	logic [alu_cfg_pkg::XLEN-1:0]      rem_q;
	logic [alu_cfg_pkg::XLEN-1:0]      dvs_q;
	logic [alu_cfg_pkg::XLEN:0]        partial;
	logic [alu_cfg_pkg::XLEN:0]        diff;
	logic                              fits;
	logic                              last_iter;

	// next partial remainder and trial subtract
	assign partial   = {rem_q, quo_q[alu_cfg_pkg::XLEN-1]};
	assign diff      = partial - {1'b0, dvs_q};
	assign fits      = ~diff[alu_cfg_pkg::XLEN];  // no borrow
	assign last_iter = (cnt_q == alu_cfg_pkg::DIV_CNT_W'(alu_cfg_pkg::DIV_ITER - 1));

	// control state
	always_ff @(posedge clock_div_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				cnt_q  <= '0;
			end else if (busy_q) begin
				cnt_q <= cnt_q + 1'b1;
				if (last_iter) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	// datapath, one quotient bit per cycle
	always_ff @(posedge clock_div_i) begin
		if (start_i) begin
			quo_q <= dividend_i;
			rem_q <= '0;
			dvs_q <= divisor_i;
		end else if (busy_q) begin
			if (fits) begin
				rem_q <= diff[alu_cfg_pkg::XLEN-1:0];
			end else begin
				rem_q <= partial[alu_cfg_pkg::XLEN-1:0];
			end
			quo_q <= {quo_q[alu_cfg_pkg::XLEN-2:0], fits};
		end
	end

	// divide by zero needs no special case, every trial fits
	assign done_o      = done_q;
	assign quotient_o  = quo_q;
	assign remainder_o = rem_q;

endmodule

// File: rtl/riscv_32m_alu.sv
`timescale 1ns/10ps

module riscv_32m_alu #(
	parameter int MUL_STAGES = alu_cfg_pkg::MUL_STAGES
) (
	input  logic                         clock_div_i,
	input  logic                         rst_n_i,
	input  logic                         start_i,
	input  logic [alu_cfg_pkg::XLEN-1:0] in0_i,     // held stable until done
	input  logic [alu_cfg_pkg::XLEN-1:0] in1_i,
	input  logic [2:0]                   func3_i,
	output logic                         done_o,
	output logic [alu_cfg_pkg::XLEN-1:0] result_o
);

	logic                                is_div;
	logic                                a_sgn;
	logic                                b_sgn;
	logic signed [alu_cfg_pkg::XLEN:0]   a_ext;
	logic signed [alu_cfg_pkg::XLEN:0]   b_ext;
	logic signed [2*alu_cfg_pkg::XLEN+1:0] prod_full;
	logic [2*alu_cfg_pkg::XLEN-1:0]      prod_q [MUL_STAGES];
	logic [MUL_STAGES-1:0]               mul_vld_q;
	logic [alu_cfg_pkg::XLEN-1:0]        mul_res;
	logic                                div_signed;
	logic                                a_neg;
	logic                                b_neg;
	logic                                div_zero;
	logic [alu_cfg_pkg::XLEN-1:0]        a_mag;
	logic [alu_cfg_pkg::XLEN-1:0]        b_mag;
	logic                                div_done;
	logic [alu_cfg_pkg::XLEN-1:0]        quo;
	logic [alu_cfg_pkg::XLEN-1:0]        rem;
	logic [alu_cfg_pkg::XLEN-1:0]        div_res;

	assign is_div = func3_i[2];

	// operand signedness per func3, extended by one bit
	assign a_sgn     = (func3_i == alu_isa_pkg::FUNC3_MULH) | (func3_i == alu_isa_pkg::FUNC3_MULHSU);
	assign b_sgn     = (func3_i == alu_isa_pkg::FUNC3_MULH);
	assign a_ext     = {a_sgn & in0_i[alu_cfg_pkg::XLEN-1], in0_i};
	assign b_ext     = {b_sgn & in1_i[alu_cfg_pkg::XLEN-1], in1_i};
	assign prod_full = a_ext * b_ext;

	always_ff @(posedge clock_div_i) begin
		prod_q[0] <= prod_full[2*alu_cfg_pkg::XLEN-1:0];
		for (int i = 1; i < MUL_STAGES; i++) begin
			prod_q[i] <= prod_q[i-1];
		end
	end

	always_ff @(posedge clock_div_i) begin
		if (!rst_n_i) begin
			mul_vld_q <= '0;
		end else begin
			mul_vld_q[0] <= start_i & ~is_div;
			for (int i = 1; i < MUL_STAGES; i++) begin
				mul_vld_q[i] <= mul_vld_q[i-1];
			end
		end
	end

	assign mul_res = (func3_i == alu_isa_pkg::FUNC3_MUL) ?
		prod_q[MUL_STAGES-1][alu_cfg_pkg::XLEN-1:0] :
		prod_q[MUL_STAGES-1][2*alu_cfg_pkg::XLEN-1:alu_cfg_pkg::XLEN];  // high word

	// divider works on magnitudes
	assign div_signed = (func3_i == alu_isa_pkg::FUNC3_DIV) | (func3_i == alu_isa_pkg::FUNC3_REM);
	assign a_neg      = div_signed & in0_i[alu_cfg_pkg::XLEN-1];
	assign b_neg      = div_signed & in1_i[alu_cfg_pkg::XLEN-1];
	assign div_zero   = (in1_i == '0);
	assign a_mag      = a_neg ? -in0_i : in0_i;
	assign b_mag      = b_neg ? -in1_i : in1_i;

	riscv_32m_div div0 (
		.clock_div_i (clock_div_i),
		.rst_n_i     (rst_n_i),
		.start_i     (start_i & is_div),
		.dividend_i  (a_mag),
		.divisor_i   (b_mag),
		.done_o      (div_done),
		.quotient_o  (quo),
		.remainder_o (rem)
	);

	// min / -1 wraps back to the dividend with these rules
	always_comb begin
		if (func3_i[1]) begin
			div_res = a_neg ? -rem : rem;  // remainder takes dividend sign
		end else if ((a_neg ^ b_neg) && !div_zero) begin
			div_res = -quo;
		end else begin
			div_res = quo;  // all ones on x/0
		end
	end

	assign done_o   = mul_vld_q[MUL_STAGES-1] | div_done;
	assign result_o = is_div ? div_res : mul_res;

endmodule

// File: rtl/riscv_alu_pipelined.sv
`timescale 1ns/10ps

module riscv_alu_pipelined #(
	parameter int RV32M = 1
) (
	input  logic                         clock_div_i,
	input  logic                         rst_n_i,
	input  logic                         in_valid_i,
	input  logic                         out_ready_i,
	input  logic [alu_cfg_pkg::XLEN-1:0] in0_i,
	input  logic [alu_cfg_pkg::XLEN-1:0] in1_i,
	input  logic [alu_cfg_pkg::XLEN-1:0] imm0_i,
	input  logic [alu_cfg_pkg::XLEN-1:0] addr_i,
	input  logic [15:0]                  encoding_i,
	input  logic [2:0]                   func3_i,
	input  logic [6:0]                   func7_i,
	output logic                         in_ready_o,
	output logic                         out_valid_o,
	output logic [alu_cfg_pkg::XLEN-1:0] result_o
);

	logic                         busy_q;    // operation in a unit
	logic                         full_q;    // result waiting for consumer
	logic                         start_q;
	logic                         accept;
	logic                         is_m_op;
	logic                         is_m_q;
	logic                         finish;
	logic [alu_cfg_pkg::XLEN-1:0] in0_q;
	logic [alu_cfg_pkg::XLEN-1:0] in1_q;
	logic [alu_cfg_pkg::XLEN-1:0] imm0_q;
	logic [alu_cfg_pkg::XLEN-1:0] addr_q;
	logic [15:0]                  enc_q;
	logic [2:0]                   func3_q;
	logic [6:0]                   func7_q;
	logic [alu_cfg_pkg::XLEN-1:0] i_result;
	logic [alu_cfg_pkg::XLEN-1:0] m_result;
	logic                         m_done;
	logic [alu_cfg_pkg::XLEN-1:0] result_q;

	assign in_ready_o = ~busy_q & ~full_q;
	assign accept     = in_valid_i & in_ready_o;
	assign is_m_op    = (RV32M != 0) && (encoding_i == alu_isa_pkg::ENCODING_ARITH_REG) &&
		(func7_i == alu_isa_pkg::RV32M_FUNC7);
	assign finish     = busy_q & (~is_m_q | m_done);  // i ops finish in one cycle

	always_ff @(posedge clock_div_i) begin
		if (!rst_n_i) begin
			busy_q  <= 1'b0;
			full_q  <= 1'b0;
			start_q <= 1'b0;
		end else begin
			start_q <= accept & is_m_op;
			if (accept) begin
				busy_q <= 1'b1;
			end else if (finish) begin
				busy_q <= 1'b0;
				full_q <= 1'b1;
			end else if (full_q && out_ready_i) begin
				full_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock_div_i) begin
		if (accept) begin
			in0_q   <= in0_i;
			in1_q   <= in1_i;
			imm0_q  <= imm0_i;
			addr_q  <= addr_i;
			enc_q   <= encoding_i;
			func3_q <= func3_i;
			func7_q <= func7_i;
			is_m_q  <= is_m_op;
		end
		if (finish) begin
			result_q <= is_m_q ? m_result : i_result;
		end
	end

	riscv_32i_alu alu_i0 (
		.in0_i      (in0_q),
		.in1_i      (in1_q),
		.imm0_i     (imm0_q),
		.addr_i     (addr_q),
		.encoding_i (enc_q),
		.func3_i    (func3_q),
		.func7_i    (func7_q),
		.out_o      (i_result)
	);

	generate
		if (RV32M != 0) begin : g_m
			riscv_32m_alu alu_m0 (
				.clock_div_i (clock_div_i),
				.rst_n_i     (rst_n_i),
				.start_i     (start_q),
				.in0_i       (in0_q),
				.in1_i       (in1_q),
				.func3_i     (func3_q),
				.done_o      (m_done),
				.result_o    (m_result)
			);
		end else begin : g_no_m
			assign m_done   = 1'b0;  // m ops decode as rv32i
			assign m_result = '0;
		end
	endgenerate

	assign out_valid_o = full_q;
	assign result_o    = result_q;

endmodule

// File: testbench/tb_riscv_alu.sv
`timescale 1ns/10ps

module tb_riscv_alu;

	localparam int MAX_VEC  = 64;
	localparam int WAIT_MAX = 100;  // cycles per handshake wait

	logic        clk;
	logic        rst_n_i;
	logic        in_valid_i;
	logic        out_ready_i;
	logic [31:0] in0_i;
	logic [31:0] in1_i;
	logic [31:0] imm0_i;
	logic [31:0] addr_i;
	logic [15:0] encoding_i;
	logic [2:0]  func3_i;
	logic [6:0]  func7_i;
	logic        in_ready_o;
	logic        out_valid_o;
	logic [31:0] result_o;

	logic [15:0] vec_enc [MAX_VEC];
	logic [2:0]  vec_f3 [MAX_VEC];
	logic [6:0]  vec_f7 [MAX_VEC];
	logic [31:0] vec_a [MAX_VEC];
	logic [31:0] vec_b [MAX_VEC];
	logic [31:0] vec_imm [MAX_VEC];
	logic [31:0] vec_addr [MAX_VEC];
	logic [31:0] vec_exp [MAX_VEC];
	int          n_vec;
	int          err_cnt;
	int          timeout_cnt;
	logic [31:0] rng_state;

	riscv_alu_pipelined #(
		.RV32M (1)
	) dut0 (
		.clock_div_i (clk),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (in_valid_i),
		.out_ready_i (out_ready_i),
		.in0_i       (in0_i),
		.in1_i       (in1_i),
		.imm0_i      (imm0_i),
		.addr_i      (addr_i),
		.encoding_i  (encoding_i),
		.func3_i     (func3_i),
		.func7_i     (func7_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.result_o    (result_o)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task load_vectors;
		int                 fd;
		int                 n_fields;
		logic [8*160-1:0]   line_buf;
		logic [31:0]        f [8];
		fd = $fopen("testbench/alu_input_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file testbench/alu_input_vectors.txt");
			err_cnt++;
		end else begin
			while ($fgets(line_buf, fd) != 0 && n_vec < MAX_VEC) begin
				n_fields = $sscanf(line_buf, "%h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				if (n_fields == 8) begin  // comment and blank lines fall through
					vec_enc[n_vec]  = f[0][15:0];
					vec_f3[n_vec]   = f[1][2:0];
					vec_f7[n_vec]   = f[2][6:0];
					vec_a[n_vec]    = f[3];
					vec_b[n_vec]    = f[4];
					vec_imm[n_vec]  = f[5];
					vec_addr[n_vec] = f[6];
					vec_exp[n_vec]  = f[7];
					n_vec++;
				end
			end
			$fclose(fd);
			if (n_vec == 0) begin
				$display("No vectors were read from the vector file");
				err_cnt++;
			end
		end
	endtask

	task drive_vectors;
		int idx;
		int waited;
		for (idx = 0; idx < n_vec && timeout_cnt == 0; idx++) begin
			@(negedge clk);
			waited = 0;
			while (!in_ready_o && waited < WAIT_MAX) begin
				in_valid_i = 1'b0;
				@(negedge clk);
				waited++;
			end
			if (in_ready_o) begin
				encoding_i = vec_enc[idx];
				func3_i    = vec_f3[idx];
				func7_i    = vec_f7[idx];
				in0_i      = vec_a[idx];
				in1_i      = vec_b[idx];
				imm0_i     = vec_imm[idx];
				addr_i     = vec_addr[idx];
				in_valid_i = 1'b1;  // accepted on the next rising edge
			end else begin
				$display("Timed out waiting for in_ready_o before vector %0d", idx);
				timeout_cnt++;
			end
		end
		@(negedge clk);
		in_valid_i = 1'b0;
	endtask

	// back-pressure and collection share one falling-edge loop
	task collect_results;
		int          idx;
		int          waited;
		logic        got;
		logic        held;
		logic [31:0] held_val;
		held     = 1'b0;
		held_val = '0;
		for (idx = 0; idx < n_vec && timeout_cnt == 0; idx++) begin
			waited = 0;
			got    = 1'b0;
			while (!got && waited < WAIT_MAX) begin
				@(negedge clk);
				waited++;
				if (held) begin
					assert (out_valid_o && result_o == held_val) else begin
						$display("Fail %0t: held result changed to %h (valid %b), was %h",
							$time, result_o, out_valid_o, held_val);
						err_cnt++;
					end
				end
				rng_state   = xorshift32(rng_state);
				out_ready_i = (rng_state % 10) < 7;
				held        = out_valid_o && !out_ready_i;
				held_val    = result_o;
				if (out_valid_o && out_ready_i) begin  // transfer on the next rising edge
					got = 1'b1;
					assert (result_o == vec_exp[idx]) else begin
						$display("Fail %0t: vector %0d gave %h, expected %h",
							$time, idx, result_o, vec_exp[idx]);
						err_cnt++;
					end
				end
			end
			if (!got) begin
				$display("Timed out waiting for the result of vector %0d", idx);
				timeout_cnt++;
			end
		end
		@(negedge clk);
		assert (!out_valid_o) else begin  // nothing beyond the last vector
			$display("Fail %0t: extra result %h after the last vector", $time, result_o);
			err_cnt++;
		end
	endtask

	initial begin
		clk         = 1'b0;
		rst_n_i     = 1'b0;
		in_valid_i  = 1'b0;
		out_ready_i = 1'b0;
		in0_i       = '0;
		in1_i       = '0;
		imm0_i      = '0;
		addr_i      = '0;
		encoding_i  = '0;
		func3_i     = '0;
		func7_i     = '0;
		n_vec       = 0;
		err_cnt     = 0;
		timeout_cnt = 0;
		rng_state   = 32'd68;
		load_vectors();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		@(negedge clk);
		assert (!out_valid_o && in_ready_o) else begin
			$display("Fail %0t: after reset out_valid_o=%b in_ready_o=%b",
				$time, out_valid_o, in_ready_o);
			err_cnt++;
		end
		if (n_vec > 0) begin
			fork
				drive_vectors();
				collect_results();
			join
		end
		$display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: testbench/alu_input_vectors.txt
# columns, all hex: encoding func3 func7 in0 in1 imm0 addr expected
# encoding 0001 lui, 0002 auipc, 0010 op-imm, 0020 op-reg (func7 01 selects rv32m)
0020 0 00 00000005 00000007 00000000 00000000 0000000c  # add
0020 0 20 00000005 00000007 00000000 00000000 fffffffe  # sub
0010 0 00 ffffffff 00000000 00000010 00000000 0000000f  # addi
0020 1 00 00000003 00000024 00000000 00000000 00000030  # sll, shamt from low 5 bits
0020 5 20 f0000000 00000004 00000000 00000000 ff000000  # sra
0010 5 00 f0000000 00000000 00000004 00000000 0f000000  # srli
0010 5 20 80000010 00000000 00000404 00000000 f8000001  # srai
0020 2 00 ffffffff 00000001 00000000 00000000 00000001  # slt
0020 3 00 ffffffff 00000001 00000000 00000000 00000000  # sltu
0020 4 00 ff00ff00 0ff00ff0 00000000 00000000 f0f0f0f0  # xor
0010 6 00 12340000 00000000 00005678 00000000 12345678  # ori
0020 7 00 f0f0f0f0 ff00ff00 00000000 00000000 f000f000  # and
0001 0 00 00000000 00000000 abcde000 00000000 abcde000  # lui
0002 0 00 00000000 00000000 00001000 00000400 00001400  # auipc
0020 0 01 fffffffd 00000007 00000000 00000000 ffffffeb  # mul
0020 1 01 80000000 80000000 00000000 00000000 40000000  # mulh
0020 2 01 ffffffff ffffffff 00000000 00000000 ffffffff  # mulhsu
0020 3 01 ffffffff ffffffff 00000000 00000000 fffffffe  # mulhu
0020 4 01 ffffffec 00000006 00000000 00000000 fffffffd  # div
0020 5 01 ffffffec 00000006 00000000 00000000 2aaaaaa7  # divu
0020 6 01 ffffffec 00000006 00000000 00000000 fffffffe  # rem
0020 7 01 ffffffec 00000006 00000000 00000000 00000002  # remu
0020 4 01 00000007 00000000 00000000 00000000 ffffffff  # div by zero
0020 6 01 fffffff9 00000000 00000000 00000000 fffffff9  # rem by zero
0020 4 01 80000000 ffffffff 00000000 00000000 80000000  # div overflow
0020 6 01 80000000 ffffffff 00000000 00000000 00000000  # rem overflow

// File: compile.f
rtl/alu_isa_pkg.sv
rtl/alu_cfg_pkg.sv
rtl/riscv_32i_alu.sv
rtl/riscv_32m_div.sv
rtl/riscv_32m_alu.sv
rtl/riscv_alu_pipelined.sv
testbench/tb_riscv_alu.sv

// File: Bender.yml
package:
  name: riscv_alu_pipelined

sources:
  - rtl/alu_isa_pkg.sv
  - rtl/alu_cfg_pkg.sv
  - rtl/riscv_32i_alu.sv
  - rtl/riscv_32m_div.sv
  - rtl/riscv_32m_alu.sv
  - rtl/riscv_alu_pipelined.sv
  - target: test
    files:
      - testbench/tb_riscv_alu.sv
